//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - .

sources:
  - mips_pkg.sv
  - mips_fetch.sv
  - mips_regfile.sv
  - mips_decode.sv
  - mips_execute.sv
  - mips_memory.sv
  - mips_core.sv
  - target: test
    files:
      - tb_mips_mem.sv
      - tb_mips_core.sv

//--- filelist.f
+incdir+.
mips_pkg.sv
mips_fetch.sv
mips_regfile.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips_core.sv
tb_mips_mem.sv
tb_mips_core.sv

//--- mips_config.svh
// global sizing for the pipelined MIPS core
// data path width, register file geometry and the reset PC
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// width of data words and byte addresses
`define MIPS_XLEN 32

// bits in a register specifier (rs, rt, rd fields)
`define MIPS_REG_AW 5

// architectural integer registers, r0 included
`define MIPS_NUM_REGS 32

// first instruction fetched after reset
// start of the user text segment in the usual MIPS memory map
`define MIPS_TEXT_START 32'h00400000

`endif

//--- mips_core.sv
// top of the five-stage pipelined MIPS core
// fetch, decode, execute and memory stages around the register file
// instruction and data memories sit outside
`timescale 1ns/10ps
`include "mips_config.svh"

module mips_core (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic [`MIPS_XLEN-1:0] inst,
   input  logic [`MIPS_XLEN-1:0] mem_data_out,
   output logic [29:0]           inst_addr,
   output logic [29:0]           mem_addr,
   output logic [`MIPS_XLEN-1:0] mem_data_in,
   output logic [3:0]            mem_write_en,
   output logic                  halted
);

   mips_pkg::if_id_t        if_id;
   mips_pkg::id_ex_t        id_ex;
   mips_pkg::ex_mem_t       ex_mem;
   mips_pkg::wb_t           wb;
   mips_pkg::redirect_t     redirect;
   logic                    hold;
   logic [`MIPS_REG_AW-1:0] rs;
   logic [`MIPS_REG_AW-1:0] rt;
   logic [`MIPS_XLEN-1:0]   rs_data;
   logic [`MIPS_XLEN-1:0]   rt_data;

   mips_fetch fetch_i (
      .clk, .rst_b, .hold, .redirect, .inst, .inst_addr, .if_id
   );

   // read ports are addressed straight from the IF/ID instruction
   mips_regfile regfile_i (
      .clk, .rst_b, .rs, .rt, .wb, .rs_data, .rt_data
   );

   mips_decode decode_i (
      .clk, .rst_b, .if_id, .redirect, .rs_data, .rt_data, .rs, .rt, .hold, .id_ex
   );

   mips_execute execute_i (
      .clk, .rst_b, .id_ex, .wb, .redirect, .ex_mem
   );

   mips_memory memory_i (
      .clk, .rst_b, .ex_mem, .mem_data_out, .mem_addr, .mem_data_in, .mem_write_en,
      .wb, .halted
   );

endmodule

//--- mips_decode.sv
// decode stage
// field split, control decode and immediate extension
// load-use stall and halt-pending detection
// ID/EX pipeline register
`timescale 1ns/10ps
`include "mips_config.svh"

module mips_decode (
   input  logic                    clk,
   input  logic                    rst_b,
   input  mips_pkg::if_id_t        if_id,
   input  mips_pkg::redirect_t     redirect,
   input  logic [`MIPS_XLEN-1:0]   rs_data,
   input  logic [`MIPS_XLEN-1:0]   rt_data,
   output logic [`MIPS_REG_AW-1:0] rs,
   output logic [`MIPS_REG_AW-1:0] rt,
   output logic                    hold,
   output mips_pkg::id_ex_t        id_ex
);

   mips_pkg::opcode_e       opcode;
   mips_pkg::funct_e        funct;
   mips_pkg::ctrl_t         ctrl;
   logic [`MIPS_REG_AW-1:0] rd;
   logic [`MIPS_REG_AW-1:0] dest;
   logic [15:0]             imm16;
   logic [`MIPS_XLEN-1:0]   imm;
   logic                    writes;
   logic                    zero_ext;
   logic                    load_use;
   logic                    halt_pending;

   assign opcode = mips_pkg::opcode_e'(if_id.inst[31:26]);
   assign rs     = if_id.inst[25:21];
   assign rt     = if_id.inst[20:16];
   assign rd     = if_id.inst[15:11];
   assign funct  = mips_pkg::funct_e'(if_id.inst[5:0]);
   assign imm16  = if_id.inst[15:0];

   // logic immediates are zero extended, LUI takes the raw 16 bits
   assign imm = zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

   always_comb begin
      ctrl     = '0;
      writes   = 1'b0;
      zero_ext = 1'b0;
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            writes = 1'b1;
            case (funct)
               mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  ctrl.alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
               mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA:  ctrl.alu_op = mips_pkg::ALU_SRA;
               mips_pkg::FN_SYSCALL: begin
                  writes    = 1'b0;
                  ctrl.halt = 1'b1;
               end
               // unknown funct behaves as a no-op
               default: writes = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
         mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_LW: begin
            writes           = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            zero_ext         = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI) ||
                               (opcode == mips_pkg::OP_XORI) || (opcode == mips_pkg::OP_LUI);
            ctrl.mem_read    = (opcode == mips_pkg::OP_LW);
            case (opcode)
               mips_pkg::OP_SLTI: ctrl.alu_op = mips_pkg::ALU_SLT;
               mips_pkg::OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
               mips_pkg::OP_ORI:  ctrl.alu_op = mips_pkg::ALU_OR;
               mips_pkg::OP_XORI: ctrl.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::OP_LUI:  ctrl.alu_op = mips_pkg::ALU_LUI;
               default:           ctrl.alu_op = mips_pkg::ALU_ADD;
            endcase
         end
         mips_pkg::OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
         end
         // both compare in execute, no register result
         mips_pkg::OP_BEQ: ctrl.branch_eq = 1'b1;
         mips_pkg::OP_BNE: ctrl.branch_ne = 1'b1;
         default: ;
      endcase
      // rd for R-type, rt for immediates, zero when nothing is written
      dest           = writes ? ((opcode == mips_pkg::OP_RTYPE) ? rd : rt) : '0;
      ctrl.reg_write = writes && (dest != '0);
   end

   // load in execute feeding this instruction needs one bubble
   assign load_use = id_ex.ctrl.mem_read && (id_ex.dest != '0) &&
                     ((id_ex.dest == rs) || (id_ex.dest == rt));
   assign hold = load_use || halt_pending;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halt_pending <= 1'b0;
         id_ex        <= '0;
      end else begin
         // syscall really issued, not squashed by an older branch
         if (ctrl.halt && !hold && !redirect.taken) begin
            halt_pending <= 1'b1;
         end
         if (hold || redirect.taken) begin
            id_ex <= '0;
         end else begin
            id_ex.pc      <= if_id.pc;
            id_ex.ctrl    <= ctrl;
            id_ex.rs_data <= rs_data;
            id_ex.rt_data <= rt_data;
            id_ex.imm     <= imm;
            id_ex.shamt   <= if_id.inst[10:6];
            id_ex.rs      <= rs;
            id_ex.rt      <= rt;
            id_ex.dest    <= dest;
         end
      end
   end

endmodule

//--- mips_execute.sv
// execute stage
// operand forwarding from EX/MEM and MEM/WB
// ALU, branch compare and target
// EX/MEM pipeline register
`timescale 1ns/10ps
`include "mips_config.svh"

module mips_execute (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::id_ex_t    id_ex,
   input  mips_pkg::wb_t       wb,
   output mips_pkg::redirect_t redirect,
   output mips_pkg::ex_mem_t   ex_mem
);

   logic [`MIPS_XLEN-1:0] rs_fwd;
   logic [`MIPS_XLEN-1:0] rt_fwd;
   logic [`MIPS_XLEN-1:0] op_b;
   logic [`MIPS_XLEN-1:0] alu_result;
   logic                  branch_hit;

   // youngest producer wins, r0 is never forwarded
   function automatic logic [`MIPS_XLEN-1:0] fwd_pick(
      input logic [`MIPS_REG_AW-1:0] src,
      input logic [`MIPS_XLEN-1:0]   reg_data,
      input mips_pkg::ex_mem_t       mem_e,
      input mips_pkg::wb_t           wb_e
   );
      if (mem_e.reg_write && (mem_e.dest != '0) && (mem_e.dest == src)) begin
         return mem_e.alu_result;
      end else if (wb_e.reg_write && (wb_e.dest != '0) && (wb_e.dest == src)) begin
         return wb_e.wr_data;
      end
      return reg_data;
   endfunction

   assign rs_fwd = fwd_pick(id_ex.rs, id_ex.rs_data, ex_mem, wb);
   assign rt_fwd = fwd_pick(id_ex.rt, id_ex.rt_data, ex_mem, wb);

   // second operand is the immediate for I-type and memory ops
   assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_fwd;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         mips_pkg::ALU_ADD:  alu_result = rs_fwd + op_b;
         mips_pkg::ALU_SUB:  alu_result = rs_fwd - op_b;
         mips_pkg::ALU_AND:  alu_result = rs_fwd & op_b;
         mips_pkg::ALU_OR:   alu_result = rs_fwd | op_b;
         mips_pkg::ALU_XOR:  alu_result = rs_fwd ^ op_b;
         mips_pkg::ALU_NOR:  alu_result = ~(rs_fwd | op_b);
         mips_pkg::ALU_SLT:  alu_result = `MIPS_XLEN'($signed(rs_fwd) < $signed(op_b));
         mips_pkg::ALU_SLTU: alu_result = `MIPS_XLEN'(rs_fwd < op_b);
         // shifts move rt by the shamt field
         mips_pkg::ALU_SLL:  alu_result = op_b << id_ex.shamt;
         mips_pkg::ALU_SRL:  alu_result = op_b >> id_ex.shamt;
         mips_pkg::ALU_SRA:  alu_result = $signed(op_b) >>> id_ex.shamt;
         mips_pkg::ALU_LUI:  alu_result = op_b << 16;
         default:            alu_result = '0;
      endcase
   end

   // branches resolve here on the forwarded operands
   assign branch_hit = (id_ex.ctrl.branch_eq && (rs_fwd == rt_fwd)) ||
                       (id_ex.ctrl.branch_ne && (rs_fwd != rt_fwd));
   assign redirect.taken  = branch_hit;
   assign redirect.target = id_ex.pc + `MIPS_XLEN'(4) +
                            {id_ex.imm[`MIPS_XLEN-3:0], 2'b00};

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_mem <= '0;
      end else begin
         ex_mem.reg_write  <= id_ex.ctrl.reg_write;
         ex_mem.mem_read   <= id_ex.ctrl.mem_read;
         ex_mem.mem_write  <= id_ex.ctrl.mem_write;
         ex_mem.halt       <= id_ex.ctrl.halt;
         ex_mem.dest       <= id_ex.dest;
         ex_mem.alu_result <= alu_result;
         // store data sees the forwarded rt as well
         ex_mem.store_data <= rt_fwd;
      end
   end

   // decode must hand over a defined operation for every writing entry
   a_alu_op_known: assert property (@(posedge clk) disable iff (!rst_b)
      id_ex.ctrl.reg_write |-> !$isunknown(id_ex.ctrl.alu_op));

endmodule

//--- mips_fetch.sv
// fetch stage
// PC register with branch redirect and stall hold
// IF/ID pipeline register
`timescale 1ns/10ps
`include "mips_config.svh"

module mips_fetch (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic                  hold,
   input  mips_pkg::redirect_t   redirect,
   input  logic [`MIPS_XLEN-1:0] inst,
   output logic [29:0]           inst_addr,
   output mips_pkg::if_id_t      if_id
);

   logic [`MIPS_XLEN-1:0] pc;

   // memories are word addressed
   assign inst_addr = pc[`MIPS_XLEN-1:2];

   // a taken branch wins over a decode stall
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc    <= `MIPS_TEXT_START;
         if_id <= '0;
      end else if (redirect.taken) begin
         pc    <= redirect.target;
         // wrong-path instruction is dropped
         if_id <= '0;
      end else if (!hold) begin
         pc       <= pc + `MIPS_XLEN'(4);
         if_id.pc <= pc;
         if_id.inst <= inst;
      end
   end

   // branch targets from execute must keep the PC on a word boundary
   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_b)
      pc[1:0] == 2'b00);

endmodule

//--- mips_memory.sv
// memory stage
// data port drive and load or ALU result select
// MEM/WB pipeline register and sticky halt flag
`timescale 1ns/10ps
`include "mips_config.svh"

module mips_memory (
   input  logic                  clk,
   input  logic                  rst_b,
   input  mips_pkg::ex_mem_t     ex_mem,
   input  logic [`MIPS_XLEN-1:0] mem_data_out,
   output logic [29:0]           mem_addr,
   output logic [`MIPS_XLEN-1:0] mem_data_in,
   output logic [3:0]            mem_write_en,
   output mips_pkg::wb_t         wb,
   output logic                  halted
);

   // word stores only, so every byte lane is enabled together
   assign mem_addr     = ex_mem.alu_result[`MIPS_XLEN-1:2];
   assign mem_data_in  = ex_mem.store_data;
   assign mem_write_en = {4{ex_mem.mem_write}};

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb     <= '0;
         halted <= 1'b0;
      end else begin
         wb.reg_write <= ex_mem.reg_write;
         wb.dest      <= ex_mem.dest;
         // the RAM answers in the same cycle
         wb.wr_data   <= ex_mem.mem_read ? mem_data_out : ex_mem.alu_result;
         // older writes drain on this same edge
         if (ex_mem.halt) begin
            halted <= 1'b1;
         end
      end
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_b)
      !(ex_mem.mem_read && ex_mem.mem_write));

endmodule

//--- mips_pkg.sv
// shared types of the pipelined MIPS core
// opcode, funct and ALU operation encodings
// control bundle and the packed pipeline register layouts
`include "mips_config.svh"

package mips_pkg;

   // primary opcodes of the supported subset
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,
      OP_SLTI  = 6'h0a,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_e;

   // funct field of R-type instructions
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a,
      FN_SLTU    = 6'h2b
   } funct_e;

   // add is zero so a bubble carries a harmless op
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src_imm;
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    branch_eq;
      logic    branch_ne;
      logic    halt;
   } ctrl_t;

   typedef struct packed {
      logic [`MIPS_XLEN-1:0] pc;
      logic [`MIPS_XLEN-1:0] inst;
   } if_id_t;

   typedef struct packed {
      logic [`MIPS_XLEN-1:0]   pc;
      ctrl_t                   ctrl;
      logic [`MIPS_XLEN-1:0]   rs_data;
      logic [`MIPS_XLEN-1:0]   rt_data;
      logic [`MIPS_XLEN-1:0]   imm;
      logic [4:0]              shamt;
      logic [`MIPS_REG_AW-1:0] rs;
      logic [`MIPS_REG_AW-1:0] rt;
      logic [`MIPS_REG_AW-1:0] dest;
   } id_ex_t;

   typedef struct packed {
      logic                    reg_write;
      logic                    mem_read;
      logic                    mem_write;
      logic                    halt;
      logic [`MIPS_REG_AW-1:0] dest;
      logic [`MIPS_XLEN-1:0]   alu_result;
      logic [`MIPS_XLEN-1:0]   store_data;
   } ex_mem_t;

   // writeback bundle, also the MEM/WB register
   typedef struct packed {
      logic                    reg_write;
      logic [`MIPS_REG_AW-1:0] dest;
      logic [`MIPS_XLEN-1:0]   wr_data;
   } wb_t;

   typedef struct packed {
      logic                  taken;
      logic [`MIPS_XLEN-1:0] target;
   } redirect_t;

endpackage

//--- mips_regfile.sv
// integer register file
// two combinational read ports with write-through from writeback
// one write port fed by the MEM/WB register
`timescale 1ns/10ps
`include "mips_config.svh"

module mips_regfile (
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic [`MIPS_REG_AW-1:0] rs,
   input  logic [`MIPS_REG_AW-1:0] rt,
   input  mips_pkg::wb_t           wb,
   output logic [`MIPS_XLEN-1:0]   rs_data,
   output logic [`MIPS_XLEN-1:0]   rt_data
);

   logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

   // r0 is hardwired, a same-cycle write is returned directly
   assign rs_data = (rs == '0) ? '0 :
                    (wb.reg_write && (wb.dest == rs)) ? wb.wr_data : regs[rs];
   assign rt_data = (rt == '0) ? '0 :
                    (wb.reg_write && (wb.dest == rt)) ? wb.wr_data : regs[rt];

   always_ff @(posedge clk) begin
      if (wb.reg_write && (wb.dest != '0)) begin
         regs[wb.dest] <= wb.wr_data;
      end
   end

   // decode already clears reg_write for writes aimed at r0
   a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_b)
      wb.reg_write |-> (wb.dest != '0));

endmodule

//--- tb_mips_core.sv
// testbench for the pipelined MIPS core
// clock and reset, instruction encoders and the store log compare
// directed tests for reset state, ALU and forwarding, load-use, branches and r0
`timescale 1ns/10ps
`include "mips_config.svh"

module tb_mips_core;

   // data segment base, r3 holds it in every program
   localparam logic [31:0] DATA_BASE = 32'h10010000;

   logic        clk;
   logic        rst_b;
   logic [31:0] inst;
   logic [31:0] mem_data_out;
   logic [29:0] inst_addr;
   logic [29:0] mem_addr;
   logic [31:0] mem_data_in;
   logic [3:0]  mem_write_en;
   logic        halted;

   integer      seed;
   int          prog_len;
   int          st_off;
   int          exp_n;
   logic [29:0] exp_addr [64];
   logic [31:0] exp_data [64];

   mips_core dut_i (
      .clk, .rst_b, .inst, .mem_data_out, .inst_addr, .mem_addr, .mem_data_in,
      .mem_write_en, .halted
   );

   tb_mips_mem mem_i (
      .clk, .rst_b, .inst_addr, .inst, .mem_addr, .mem_data_in, .mem_write_en, .mem_data_out
   );

   always #4 clk = ~clk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
      end
   endtask

   // instruction encoders for the R and I formats
   function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic emit(input logic [31:0] word);
      mem_i.rom[prog_len] = word;
      prog_len++;
   endtask

   // full 32-bit constant through LUI then ORI
   task automatic load_const(input logic [4:0] r, input logic [31:0] v);
      emit(enc_i(mips_pkg::OP_LUI, 0, r, v[31:16]));
      emit(enc_i(mips_pkg::OP_ORI, r, r, v[15:0]));
   endtask

   // SW of a register to the next slot, plus the entry the log must show
   task automatic store_result(input logic [4:0] r, input logic [31:0] val);
      emit(enc_i(mips_pkg::OP_SW, 3, r, 16'(st_off)));
      exp_addr[exp_n] = 30'((DATA_BASE + st_off) >> 2);
      exp_data[exp_n] = val;
      exp_n++;
      st_off += 4;
   endtask

   task automatic op_store(input logic [31:0] word, input logic [4:0] r,
                           input logic [31:0] val);
      emit(word);
      store_result(r, val);
   endtask

   // reset stays low while the next program is assembled
   task automatic start_reset();
      @(posedge clk);
      rst_b <= 1'b0;
      for (int i = 0; i < 256; i++) begin
         mem_i.rom[i] = '0;
         mem_i.ram[i] = 32'h5a5a0000 ^ (i * 32'h00009e37);
      end
      prog_len = 0;
      st_off   = 0;
      exp_n    = 0;
   endtask

   task automatic finish_reset();
      repeat (3) @(posedge clk);
      rst_b <= 1'b1;
   endtask

   task automatic wait_halt();
      int cycles;
      cycles = 0;
      while (halted !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > 500) begin
            fail_run("timeout, the core never raised halted");
         end
      end
   endtask

   // word stores must enable all four byte lanes
   task automatic compare_log();
      check("store count", mem_i.log_count, exp_n);
      for (int i = 0; i < exp_n; i++) begin
         check($sformatf("mem_addr[%0d]", i), mem_i.log_addr[i], exp_addr[i]);
         check($sformatf("mem_data_in[%0d]", i), mem_i.log_data[i], exp_data[i]);
         check($sformatf("mem_write_en[%0d]", i), mem_i.log_mask[i], 4'hf);
      end
   endtask

   task automatic run_program();
      emit(enc_r(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      finish_reset();
      wait_halt();
      compare_log();
   endtask

   task automatic test_reset_state();
      start_reset();
      @(negedge clk);
      check("inst_addr", inst_addr, `MIPS_TEXT_START >> 2);
      check("mem_write_en", mem_write_en, 0);
      check("halted", halted, 0);
      // lone syscall, nothing may be stored
      run_program();
   endtask

   task automatic test_alu_forwarding();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sum;
      logic [15:0] imm;
      logic [31:0] sx;
      a   = $random(seed);
      // sign bit set so SRA has ones to shift in
      b   = $random(seed) | 32'h80000000;
      imm = $random(seed);
      sx  = {{16{imm[15]}}, imm};
      sum = a + b;
      start_reset();
      emit(enc_i(mips_pkg::OP_LUI, 0, 3, DATA_BASE[31:16]));
      load_const(1, a);
      load_const(2, b);
      // gapless chain, operands from EX/MEM and then MEM/WB
      emit(enc_r(mips_pkg::FN_ADDU, 1, 2, 4, 0));
      emit(enc_r(mips_pkg::FN_SUBU, 4, 1, 5, 0));
      emit(enc_r(mips_pkg::FN_XOR, 5, 4, 6, 0));
      store_result(4, sum);
      store_result(5, sum - a);
      store_result(6, (sum - a) ^ sum);
      // each store takes its data from the op just ahead
      op_store(enc_r(mips_pkg::FN_AND, 1, 2, 7, 0), 7, a & b);
      op_store(enc_r(mips_pkg::FN_OR, 1, 2, 7, 0), 7, a | b);
      op_store(enc_r(mips_pkg::FN_NOR, 1, 2, 7, 0), 7, ~(a | b));
      op_store(enc_r(mips_pkg::FN_SLT, 1, 2, 8, 0), 8, {31'b0, $signed(a) < $signed(b)});
      op_store(enc_r(mips_pkg::FN_SLTU, 1, 2, 8, 0), 8, {31'b0, a < b});
      op_store(enc_r(mips_pkg::FN_SLL, 0, 1, 9, 7), 9, a << 7);
      op_store(enc_r(mips_pkg::FN_SRL, 0, 1, 9, 9), 9, a >> 9);
      op_store(enc_r(mips_pkg::FN_SRA, 0, 2, 9, 5), 9, $signed(b) >>> 5);
      op_store(enc_i(mips_pkg::OP_ADDIU, 1, 10, imm), 10, a + sx);
      op_store(enc_i(mips_pkg::OP_ANDI, 2, 10, imm), 10, b & {16'b0, imm});
      op_store(enc_i(mips_pkg::OP_ORI, 2, 10, imm), 10, b | {16'b0, imm});
      op_store(enc_i(mips_pkg::OP_XORI, 1, 10, imm), 10, a ^ {16'b0, imm});
      op_store(enc_i(mips_pkg::OP_SLTI, 1, 11, imm), 11, {31'b0, $signed(a) < $signed(sx)});
      op_store(enc_i(mips_pkg::OP_LUI, 0, 11, imm), 11, {imm, 16'b0});
      run_program();
   endtask

   task automatic test_load_use();
      logic [31:0] v;
      logic [31:0] w;
      logic [31:0] c;
      v = $random(seed);
      w = $random(seed);
      c = $random(seed);
      start_reset();
      // words 8 and 9 sit at DATA_BASE + 32 and + 36
      mem_i.ram[8] = v;
      mem_i.ram[9] = w;
      emit(enc_i(mips_pkg::OP_LUI, 0, 3, DATA_BASE[31:16]));
      load_const(2, c);
      emit(enc_i(mips_pkg::OP_LW, 3, 4, 16'd32));
      // consumer right behind the load, one bubble expected
      emit(enc_r(mips_pkg::FN_ADDU, 4, 2, 5, 0));
      store_result(5, v + c);
      // store data taken straight from a load
      emit(enc_i(mips_pkg::OP_LW, 3, 6, 16'd36));
      store_result(6, w);
      run_program();
   endtask

   task automatic test_branches();
      logic [31:0] p;
      p = $random(seed);
      start_reset();
      emit(enc_i(mips_pkg::OP_LUI, 0, 3, DATA_BASE[31:16]));
      load_const(1, p);
      emit(enc_r(mips_pkg::FN_ADDU, 1, 0, 2, 0));
      // taken BEQ, both shadow stores must vanish
      emit(enc_i(mips_pkg::OP_BEQ, 1, 2, 16'd2));
      emit(enc_i(mips_pkg::OP_SW, 3, 1, 16'h0100));
      emit(enc_i(mips_pkg::OP_SW, 3, 1, 16'h0104));
      store_result(1, p);
      // not taken, falls through
      emit(enc_i(mips_pkg::OP_BNE, 1, 2, 16'd2));
      store_result(2, p);
      emit(enc_i(mips_pkg::OP_ADDIU, 1, 5, 16'd1));
      // taken BNE on a forwarded operand, syscall in its shadow
      emit(enc_i(mips_pkg::OP_BNE, 5, 1, 16'd2));
      emit(enc_r(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      emit(enc_i(mips_pkg::OP_SW, 3, 5, 16'h0108));
      store_result(5, p + 32'd1);
      emit(enc_i(mips_pkg::OP_BEQ, 5, 1, 16'd1));
      store_result(1, p);
      run_program();
   endtask

   task automatic test_reg_zero();
      logic [31:0] q;
      q = $random(seed);
      start_reset();
      emit(enc_i(mips_pkg::OP_LUI, 0, 3, DATA_BASE[31:16]));
      load_const(1, q);
      // all of these target r0 and must leave it at zero
      emit(enc_r(mips_pkg::FN_ADDU, 1, 1, 0, 0));
      emit(enc_i(mips_pkg::OP_ORI, 1, 0, 16'hffff));
      emit(enc_i(mips_pkg::OP_LW, 3, 0, 16'd32));
      store_result(0, 32'h0);
      emit(enc_r(mips_pkg::FN_ADDU, 0, 1, 6, 0));
      store_result(6, q);
      run_program();
   endtask

   initial begin
      seed  = 57263;
      clk   = 1'b0;
      rst_b = 1'b0;
      test_reset_state();
      test_alu_forwarding();
      test_load_use();
      test_branches();
      test_reg_zero();
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- tb_mips_mem.sv
// behavioral memories for the core testbench
// instruction ROM and data RAM, both word addressed with combinational reads
// log of every data write cycle as word address, data and byte mask
`timescale 1ns/10ps

module tb_mips_mem (
   input  logic        clk,
   input  logic        rst_b,
   input  logic [29:0] inst_addr,
   output logic [31:0] inst,
   input  logic [29:0] mem_addr,
   input  logic [31:0] mem_data_in,
   input  logic [3:0]  mem_write_en,
   output logic [31:0] mem_data_out
);

   // 256 words each, indexed by the low word address bits
   logic [31:0] rom [256];
   logic [31:0] ram [256];

   // store log, read back by the test tasks
   logic [29:0] log_addr [64];
   logic [31:0] log_data [64];
   logic [3:0]  log_mask [64];
   int          log_count;

   initial begin
      for (int i = 0; i < 256; i++) begin
         rom[i] = '0;
         ram[i] = '0;
      end
      log_count = 0;
   end

   // both ports answer in the same cycle
   assign inst         = rom[inst_addr[7:0]];
   assign mem_data_out = ram[mem_addr[7:0]];

   always @(posedge clk) begin
      if (!rst_b) begin
         log_count <= 0;
      end else if (mem_write_en != 4'b0000) begin
         // byte lanes follow the write mask
         for (int lane = 0; lane < 4; lane++) begin
            if (mem_write_en[lane]) begin
               ram[mem_addr[7:0]][lane*8 +: 8] <= mem_data_in[lane*8 +: 8];
            end
         end
         if (log_count < 64) begin
            log_addr[log_count] <= mem_addr;
            log_data[log_count] <= mem_data_in;
            log_mask[log_count] <= mem_write_en;
            log_count           <= log_count + 1;
         end
      end
   end

endmodule
